// File: dv/rename_input.txt
# columns: opcode, argument, count
# R rename arch reg (99 = random) count times, S save page, L restore page,
# E exception, M mret, W wait until idle then count idle cycles
R 3 1
R 7 1
R 0 1
R 31 1
R 7 1
R 7 1
W 0 2
R 99 150
W 0 1
S 2 1
R 12 6
W 0 2
R 99 40
S 5 1
W 0 1
R 99 25
L 2 1
W 0 2
R 99 30
L 5 1
W 0 1
R 99 20
E 0 1
R 99 10
S 1 1
R 9 50
E 0 1
R 99 8
W 0 1
S 3 1
R 14 70
M 0 1
R 99 6
L 2 1
W 0 1
R 99 12

// File: vlog.f
common/rename_pkg.sv
verilog/rename_ctrl.sv
free_list/free_list.sv
free_list/checkpoint_store.sv
verilog/rename_map.sv
verilog/rename_top.sv
dv/rename_tb.sv

// File: Makefile
# Verilator build and run of the rename testbench.

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module rename_tb -o rename_tb

run: compile
	./obj_dir/rename_tb | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: dv/rename_tb.sv
module rename_tb import rename_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int pages = 8;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      rename_en;
    arch_reg_t arch_dst;
    logic      exception;
    logic      mret;
    logic      save_state;
    logic      restore_state;
    page_t     save_page;
    page_t     restore_page;
    phys_tag_t new_tag;
    phys_tag_t old_tag;
    logic      tag_valid;
    logic      busy;

    // reference model of ring, map and pages.
    phys_tag_t m_ring  [num_slots];
    phys_tag_t m_map   [num_arch];
    slot_t     m_head;
    phys_tag_t pg_ring [pages][num_slots];
    phys_tag_t pg_map  [pages][num_arch];
    slot_t     pg_head [pages];
    bit        pg_ok   [pages];

    int        busy_left;
    bit        restoring;
    page_t     walk_page;
    bit        walk_aborted;
    int        busy_run;
    logic      exp_valid;
    phys_tag_t exp_new;
    phys_tag_t exp_old;

    string     op_q  [$];
    int        arg_q [$];
    int        cnt_q [$];
    int        limit_cycles;
    int        cycle_count;
    int        n_checks;
    int        errors;
    integer    seed = 32'h1877_68c1;

    always #2 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    rename_top #(
        .num_pages     (pages)
    ) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .rename_en     (rename_en),
        .arch_dst      (arch_dst),
        .exception     (exception),
        .mret          (mret),
        .save_state    (save_state),
        .restore_state (restore_state),
        .save_page     (save_page),
        .restore_page  (restore_page),
        .new_tag       (new_tag),
        .old_tag       (old_tag),
        .tag_valid     (tag_valid),
        .busy          (busy)
    );

    task automatic model_flush();
        for (int i = 0; i < num_slots; i++) begin
            m_ring[i] = phys_tag_t'(32 + i);
        end
        for (int r = 0; r < num_arch; r++) begin
            m_map[r] = phys_tag_t'(r);
        end
        m_head = '0;
    endtask

    task automatic compare(input string what, input logic [7:0] got, input logic [7:0] want);
        n_checks++;
        assert (got === want) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // model of the clock edge that ends the current cycle.
    task automatic model_edge();
        exp_valid = 1'b0;
        if (exception || mret) begin
            if (busy_left > 0) walk_aborted = 1'b1;
            model_flush();
            busy_left = 0;
        end else if (busy_left > 0) begin
            busy_left--;
            if (busy_left == 0 && restoring) begin
                m_ring = pg_ring[walk_page];  // restore lands as busy falls.
                m_map  = pg_map[walk_page];
                m_head = pg_head[walk_page];
            end else if (busy_left == 0) begin
                pg_ok[walk_page] = 1'b1;
            end
        end else if (restore_state) begin
            busy_left    = num_slots;
            restoring    = 1'b1;
            walk_page    = restore_page;
            walk_aborted = 1'b0;
        end else begin
            if (save_state) begin
                busy_left         = num_slots;
                restoring         = 1'b0;
                walk_page         = save_page;
                walk_aborted      = 1'b0;
                pg_ok[save_page]  = 1'b0;  // only valid once the walk completes.
                pg_ring[save_page] = m_ring;
                pg_map[save_page]  = m_map;
                pg_head[save_page] = m_head;
            end
            if (rename_en) begin
                exp_new          = m_ring[m_head];
                exp_old          = m_map[arch_dst];
                m_map[arch_dst]  = exp_new;
                m_ring[m_head]   = exp_old;
                m_head           = m_head + 7'd1;
                exp_valid        = 1'b1;
            end
        end
    endtask

    task automatic check_outputs();
        compare("busy", 8'(busy), 8'(busy_left > 0));
        compare("tag_valid", 8'(tag_valid), 8'(exp_valid));
        if (exp_valid) begin
            compare("new_tag", new_tag, exp_new);
            compare("old_tag", old_tag, exp_old);
        end
        if (busy === 1'b1) begin
            busy_run++;
        end else if (busy_run > 0) begin
            if (!walk_aborted) compare("busy length", 8'(busy_run), 8'(num_slots));
            busy_run = 0;
        end
    endtask

    task automatic clear_inputs();
        rename_en     = 1'b0;
        arch_dst      = '0;
        exception     = 1'b0;
        mret          = 1'b0;
        save_state    = 1'b0;
        restore_state = 1'b0;
        save_page     = '0;
        restore_page  = '0;
    endtask

    // inputs are already driven, 0.5 ns after the last edge.
    task automatic run_cycle();
        model_edge();
        @(posedge clk);
        #0.5;
        check_outputs();
        clear_inputs();
    endtask

    task automatic do_op(input string op, input int arg, input int cnt);
        case (op)
            "R": begin
                for (int n = 0; n < cnt; n++) begin
                    rename_en = 1'b1;
                    arch_dst  = (arg == 99) ? arch_reg_t'($random(seed)) : arch_reg_t'(arg);
                    run_cycle();
                end
            end
            "S": begin
                save_state = 1'b1;
                save_page  = page_t'(arg);
                run_cycle();
            end
            "L": begin
                if (!pg_ok[page_t'(arg)]) begin
                    errors++;
                    $display("stimulus restores page %0d, which holds no complete save", arg);
                end else begin
                    restore_state = 1'b1;
                    restore_page  = page_t'(arg);
                    run_cycle();
                end
            end
            "E": begin
                exception = 1'b1;
                run_cycle();
            end
            "M": begin
                mret = 1'b1;
                run_cycle();
            end
            "W": begin
                while (busy !== 1'b0) run_cycle();
                repeat (cnt) run_cycle();
            end
            default: begin
                errors++;
                $display("unknown opcode %s in the stimulus file", op);
            end
        endcase
    endtask

    task automatic read_stimulus();
        int    fd;
        int    n;
        int    a;
        int    c;
        string line;
        string tok;
        fd = $fopen("dv/rename_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open dv/rename_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && $sscanf(line, "%s %d %d", tok, a, c) == 3 && tok[0] != "#") begin
                    op_q.push_back(tok);
                    arg_q.push_back(a);
                    cnt_q.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        clear_inputs();
        model_flush();  // reset contents equal the flush contents.
        exp_valid = 1'b0;
        read_stimulus();
        limit_cycles = op_q.size() * 140 + 100;
        repeat (8) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        check_outputs();
        foreach (op_q[i]) begin
            do_op(op_q[i], arg_q[i], cnt_q[i]);
        end
        $display("checks: %0d, errors: %0d", n_checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles != 0 && cycle_count >= limit_cycles);
        $display("timeout: the run did not end within %0d cycles", limit_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: verilog/rename_top.sv
module rename_top import rename_pkg::*; #(
    parameter int num_pages = 8
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rename_en,
    input  arch_reg_t arch_dst,
    input  logic      exception,
    input  logic      mret,
    input  logic      save_state,
    input  logic      restore_state,
    input  page_t     save_page,
    input  page_t     restore_page,
    output phys_tag_t new_tag,
    output phys_tag_t old_tag,
    output logic      tag_valid,
    output logic      busy
);

    logic      alloc;
    logic      flush;
    logic      copy_save;
    logic      copy_restore;
    slot_t     copy_slot;
    page_t     copy_page;

    phys_tag_t head_tag;
    phys_tag_t slot_tag;
    slot_t     head;
    phys_tag_t cur_tag;
    phys_tag_t map_slot_tag;
    phys_tag_t restore_tag;
    phys_tag_t restore_map_tag;
    slot_t     restore_head;

    rename_ctrl #(
        .num_pages     (num_pages)
    ) u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .rename_en     (rename_en),
        .exception     (exception),
        .mret          (mret),
        .save_state    (save_state),
        .restore_state (restore_state),
        .save_page     (save_page),
        .restore_page  (restore_page),
        .alloc         (alloc),
        .flush         (flush),
        .copy_save     (copy_save),
        .copy_restore  (copy_restore),
        .copy_slot     (copy_slot),
        .copy_page     (copy_page),
        .busy          (busy),
        .tag_valid     (tag_valid)
    );

    // old map entry goes back into the ring.
    free_list u_free_list (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .alloc         (alloc),
        .free_tag      (cur_tag),
        .copy_restore  (copy_restore),
        .copy_slot     (copy_slot),
        .restore_tag   (restore_tag),
        .restore_head  (restore_head),
        .head_tag      (head_tag),
        .slot_tag      (slot_tag),
        .head          (head),
        .new_tag       (new_tag)
    );

    checkpoint_store #(
        .num_pages       (num_pages)
    ) u_ckpt (
        .clk             (clk),
        .copy_save       (copy_save),
        .copy_restore    (copy_restore),
        .copy_page       (copy_page),
        .copy_slot       (copy_slot),
        .slot_tag        (slot_tag),
        .map_slot_tag    (map_slot_tag),
        .head            (head),
        .restore_tag     (restore_tag),
        .restore_map_tag (restore_map_tag),
        .restore_head    (restore_head)
    );

    rename_map u_map (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .alloc           (alloc),
        .arch_dst        (arch_dst),
        .new_alloc_tag   (head_tag),
        .copy_restore    (copy_restore),
        .copy_slot       (copy_slot),
        .restore_map_tag (restore_map_tag),
        .cur_tag         (cur_tag),
        .map_slot_tag    (map_slot_tag),
        .old_tag         (old_tag)
    );

endmodule

// File: verilog/rename_map.sv
module rename_map import rename_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      alloc,
    input  arch_reg_t arch_dst,
    input  phys_tag_t new_alloc_tag,
    input  logic      copy_restore,
    input  slot_t     copy_slot,
    input  phys_tag_t restore_map_tag,
    output phys_tag_t cur_tag,
    output phys_tag_t map_slot_tag,
    output phys_tag_t old_tag
);

    phys_tag_t map [num_arch];

    logic      map_slot;
    arch_reg_t map_idx;

    assign map_slot = (copy_slot < slot_t'(num_arch));
    assign map_idx  = arch_reg_t'(copy_slot);

    assign cur_tag      = map[arch_dst];  // becomes the freed tag.
    assign map_slot_tag = map[map_idx];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int r = 0; r < num_arch; r++) begin
                map[r] <= phys_tag_t'(r);  // identity map.
            end
        end else if (copy_restore) begin
            if (map_slot) begin
                map[map_idx] <= restore_map_tag;
            end
        end else if (alloc) begin
            map[arch_dst] <= new_alloc_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            old_tag <= cur_tag;
        end
    end

endmodule

// File: free_list/checkpoint_store.sv
module checkpoint_store import rename_pkg::*; #(
    parameter int num_pages = 8
) (
    input  logic      clk,
    input  logic      copy_save,
    input  logic      copy_restore,
    input  page_t     copy_page,
    input  slot_t     copy_slot,
    input  phys_tag_t slot_tag,
    input  phys_tag_t map_slot_tag,
    input  slot_t     head,
    output phys_tag_t restore_tag,
    output phys_tag_t restore_map_tag,
    output slot_t     restore_head
);

    phys_tag_t ring_mem [num_pages][num_slots];
    phys_tag_t map_mem  [num_pages][num_arch];
    slot_t     head_mem [num_pages];

    logic      map_slot;
    arch_reg_t map_idx;

    // map entries only ride along on the first 32 slots.
    assign map_slot = (copy_slot < slot_t'(num_arch));
    assign map_idx  = arch_reg_t'(copy_slot);

    always_ff @(posedge clk) begin
        if (copy_save) begin
            ring_mem[copy_page][copy_slot] <= slot_tag;
            if (map_slot) begin
                map_mem[copy_page][map_idx] <= map_slot_tag;
            end
            if (copy_slot == '0) begin
                head_mem[copy_page] <= head;
            end
        end
    end

    assign restore_tag     = copy_restore ? ring_mem[copy_page][copy_slot] : '0;
    assign restore_map_tag = copy_restore ? map_mem[copy_page][map_idx] : '0;
    assign restore_head    = copy_restore ? head_mem[copy_page] : '0;

endmodule

// File: free_list/free_list.sv
module free_list import rename_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      alloc,
    input  phys_tag_t free_tag,
    input  logic      copy_restore,
    input  slot_t     copy_slot,
    input  phys_tag_t restore_tag,
    input  slot_t     restore_head,
    output phys_tag_t head_tag,
    output phys_tag_t slot_tag,
    output slot_t     head,
    output phys_tag_t new_tag
);

    phys_tag_t ring [num_slots];

    assign head_tag = ring[head];
    assign slot_tag = ring[copy_slot];  // checkpoint save path.

    // ring always holds the tags that are not mapped.
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < num_slots; i++) begin
                ring[i] <= phys_tag_t'(num_arch + i);
            end
            head <= '0;
        end else if (copy_restore) begin
            ring[copy_slot] <= restore_tag;
            if (copy_slot == '0) begin
                head <= restore_head;  // head travels with slot 0.
            end
        end else if (alloc) begin
            ring[head] <= free_tag;  // freed tag reuses the slot just read.
            head       <= head + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            new_tag <= ring[head];
        end
    end

    // the ring is rewritten slot by slot, a rename would tear it.
    a_no_alloc_restore: assert property (
        @(posedge clk) disable iff (!rst_n) !(alloc && copy_restore)
    ) else $error("alloc during restore walk");

endmodule

// File: verilog/rename_ctrl.sv
module rename_ctrl import rename_pkg::*; #(
    parameter int num_pages = 8
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rename_en,
    input  logic  exception,
    input  logic  mret,
    input  logic  save_state,
    input  logic  restore_state,
    input  page_t save_page,
    input  page_t restore_page,
    output logic  alloc,
    output logic  flush,
    output logic  copy_save,
    output logic  copy_restore,
    output slot_t copy_slot,
    output page_t copy_page,
    output logic  busy,
    output logic  tag_valid
);

    ckpt_state_t state;
    logic        save_ok;
    logic        restore_ok;
    logic        last_slot;

    assign flush      = exception | mret;
    assign restore_ok = restore_state && (int'(restore_page) < num_pages);
    assign save_ok    = save_state && (int'(save_page) < num_pages);
    assign last_slot  = (copy_slot == slot_t'(num_slots - 1));

    assign busy         = (state != ckpt_idle);
    assign copy_save    = (state == ckpt_save);
    assign copy_restore = (state == ckpt_restore);

    // a restore in the same cycle wins over the rename.
    assign alloc = rename_en && !busy && !flush && !restore_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ckpt_idle;
            copy_slot <= '0;
            copy_page <= '0;
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= alloc;  // tags come out of the datapath a cycle later.
            if (flush) begin
                state     <= ckpt_idle;  // aborts any walk.
                copy_slot <= '0;
            end else begin
                case (state)
                    ckpt_idle: begin
                        if (restore_ok) begin
                            state     <= ckpt_restore;
                            copy_page <= restore_page;
                        end else if (save_ok) begin
                            state     <= ckpt_save;
                            copy_page <= save_page;
                        end
                    end
                    default: begin
                        copy_slot <= copy_slot + 1'b1;  // wraps to 0 after the last slot.
                        if (last_slot) begin
                            state <= ckpt_idle;
                        end
                    end
                endcase
            end
        end
    end

    // every walk starts from slot 0.
    a_idle_slot_zero: assert property (
        @(posedge clk) disable iff (!rst_n) !busy |-> (copy_slot == '0)
    ) else $error("copy_slot not at 0 while idle");

    a_slot_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (copy_slot != $past(copy_slot)) |-> ($past(state) != ckpt_idle)
    ) else $error("copy_slot moved while idle");

endmodule

// File: common/rename_pkg.sv
package rename_pkg;

    localparam int num_slots = 128;  // free ring depth.
    localparam int num_arch  = 32;

    typedef logic [7:0] phys_tag_t;
    typedef logic [4:0] arch_reg_t;
    typedef logic [2:0] page_t;

    // ring slot, also the checkpoint copy index.
    typedef logic [6:0] slot_t;

    typedef enum logic [1:0] {
        ckpt_idle,
        ckpt_save,
        ckpt_restore
    } ckpt_state_t;

endpackage
